/* hw/cpu_arch_pkg.sv */
`default_nettype none

package cpu_arch_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // first fetch address after reset
    localparam logic [ADDR_W-1:0] RESET_PC = 16'h0200;

    localparam logic [DATA_W-1:0] RESET_A = '0;
    localparam logic [DATA_W-1:0] RESET_X = '0;
    localparam logic [DATA_W-1:0] RESET_Y = '0;

    localparam logic RESET_N = 1'b0;
    localparam logic RESET_Z = 1'b0;
    localparam logic RESET_C = 1'b0;

    // kept subset, 6502 encodings
    typedef enum logic [DATA_W-1:0] {
        OP_LDA_IMM = 8'hA9,
        OP_LDX_IMM = 8'hA2,
        OP_LDY_IMM = 8'hA0,
        OP_ADC_IMM = 8'h69,
        OP_SBC_IMM = 8'hE9,
        OP_AND_IMM = 8'h29,
        OP_ORA_IMM = 8'h09,
        OP_EOR_IMM = 8'h49,
        OP_TAX     = 8'hAA,
        OP_TAY     = 8'hA8,
        OP_INX     = 8'hE8,
        OP_INY     = 8'hC8,
        OP_DEX     = 8'hCA,
        OP_DEY     = 8'h88,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_NOP     = 8'hEA,
        OP_STA_ABS = 8'h8D,
        OP_STX_ABS = 8'h8E,
        OP_STY_ABS = 8'h8C,
        OP_JMP_ABS = 8'h4C,
        OP_BEQ     = 8'hF0,
        OP_BNE     = 8'hD0,
        OP_BCC     = 8'h90,
        OP_BCS     = 8'hB0,
        OP_BMI     = 8'h30,
        OP_BPL     = 8'h10
    } opcode_e;

endpackage

`default_nettype wire

/* hw/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_OPERAND,
        ST_ADDR_HI,
        ST_STORE
    } cpu_state_e;

    // HOLD keeps the ALU output register
    typedef enum logic [2:0] {
        ALU_HOLD,
        ALU_PASS,
        ALU_ADD,
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_INC,
        ALU_DEC
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A,
        SRC_X,
        SRC_Y,
        SRC_MEM
    } alu_src_e;

    typedef enum logic [2:0] {
        DST_NONE,
        DST_A,
        DST_X,
        DST_Y,
        DST_C
    } alu_dst_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_C,
        BR_Z,
        BR_N
    } branch_cond_e;

    // carry-in select
    localparam logic [1:0] CARRY_USE_C = 2'd0;
    localparam logic [1:0] CARRY_ZERO  = 2'd1;
    localparam logic [1:0] CARRY_ONE   = 2'd2;

endpackage

`default_nettype wire

/* hw/cpu_ctrl_if.sv */
`default_nettype none

interface cpu_ctrl_if;

    // execute fields
    cpu_ctrl_pkg::alu_op_e      alu_op;
    cpu_ctrl_pkg::alu_src_e     alu_src;
    logic                       operand_inv;
    logic [1:0]                 carry_sel;

    // writeback and branch fields
    cpu_ctrl_pkg::alu_dst_e     alu_dst;
    logic                       upd_nz;
    logic                       upd_c;
    cpu_ctrl_pkg::branch_cond_e branch_cond;
    logic                       branch_inv;
    cpu_ctrl_pkg::alu_src_e     store_src;
    logic                       branch_taken;

    modport decode (
        output alu_op, alu_src, operand_inv, carry_sel,
        output alu_dst, upd_nz, upd_c, branch_cond, branch_inv, store_src,
        input  branch_taken
    );

    modport execute (
        input alu_op, alu_src, operand_inv, carry_sel
    );

    modport result (
        input  alu_dst, upd_nz, upd_c, branch_cond, branch_inv, store_src,
        output branch_taken
    );

endinterface

`default_nettype wire

/* hw/cpu_alu_if.sv */
`default_nettype none

interface cpu_alu_if;

    // registered ALU result
    logic [cpu_arch_pkg::DATA_W-1:0] alu_out;
    logic                            n_out;
    logic                            z_out;
    logic                            c_out;

    // operand values back from the register file
    logic [cpu_arch_pkg::DATA_W-1:0] reg_a;
    logic [cpu_arch_pkg::DATA_W-1:0] reg_x;
    logic [cpu_arch_pkg::DATA_W-1:0] reg_y;
    logic                            reg_c;

    modport execute (
        output alu_out, n_out, z_out, c_out,
        input  reg_a, reg_x, reg_y, reg_c
    );

    modport result (
        input  alu_out, n_out, z_out, c_out,
        output reg_a, reg_x, reg_y, reg_c
    );

endinterface

`default_nettype wire

/* hw/cpu_decode.sv */
`default_nettype none

module cpu_decode (
    input  wire logic                            i_clock,
    input  wire logic                            i_rst_n,
    input  wire logic                            i_clock_en,
    input  wire logic [cpu_arch_pkg::DATA_W-1:0] i_r_data,
    output logic [cpu_arch_pkg::ADDR_W-1:0]      o_addr,
    output logic                                 o_mem_r_en,
    output logic                                 o_mem_w_en,
    cpu_ctrl_if.decode                           ctrl
);

    cpu_ctrl_pkg::cpu_state_e        state;
    cpu_ctrl_pkg::cpu_state_e        state_nxt;
    cpu_arch_pkg::opcode_e           opcode;
    logic [cpu_arch_pkg::ADDR_W-1:0] pc;
    logic [cpu_arch_pkg::ADDR_W-1:0] pc_inc;
    logic [cpu_arch_pkg::ADDR_W-1:0] pc_nxt;
    logic [cpu_arch_pkg::ADDR_W-1:0] rel_off;
    logic [cpu_arch_pkg::DATA_W-1:0] addr_lo;
    logic [cpu_arch_pkg::DATA_W-1:0] addr_hi;

    cpu_ctrl_pkg::alu_op_e           dec_op;
    cpu_ctrl_pkg::alu_src_e          dec_src;
    cpu_ctrl_pkg::alu_dst_e          dec_dst;
    logic                            needs_operand;
    logic                            is_abs;
    logic                            is_store;

    ////////////////////////////////////////////////////////////
    // opcode decode

    always_comb begin
        case (opcode)
            cpu_arch_pkg::OP_LDA_IMM, cpu_arch_pkg::OP_LDX_IMM, cpu_arch_pkg::OP_LDY_IMM,
            cpu_arch_pkg::OP_TAX, cpu_arch_pkg::OP_TAY,
            cpu_arch_pkg::OP_CLC, cpu_arch_pkg::OP_SEC: dec_op = cpu_ctrl_pkg::ALU_PASS;
            cpu_arch_pkg::OP_ADC_IMM, cpu_arch_pkg::OP_SBC_IMM: dec_op = cpu_ctrl_pkg::ALU_ADD;
            cpu_arch_pkg::OP_AND_IMM: dec_op = cpu_ctrl_pkg::ALU_AND;
            cpu_arch_pkg::OP_ORA_IMM: dec_op = cpu_ctrl_pkg::ALU_OR;
            cpu_arch_pkg::OP_EOR_IMM: dec_op = cpu_ctrl_pkg::ALU_EOR;
            cpu_arch_pkg::OP_INX, cpu_arch_pkg::OP_INY: dec_op = cpu_ctrl_pkg::ALU_INC;
            cpu_arch_pkg::OP_DEX, cpu_arch_pkg::OP_DEY: dec_op = cpu_ctrl_pkg::ALU_DEC;
            default: dec_op = cpu_ctrl_pkg::ALU_HOLD;
        endcase

        // also selects the store data
        case (opcode)
            cpu_arch_pkg::OP_ADC_IMM, cpu_arch_pkg::OP_SBC_IMM, cpu_arch_pkg::OP_AND_IMM,
            cpu_arch_pkg::OP_ORA_IMM, cpu_arch_pkg::OP_EOR_IMM, cpu_arch_pkg::OP_TAX,
            cpu_arch_pkg::OP_TAY, cpu_arch_pkg::OP_STA_ABS: dec_src = cpu_ctrl_pkg::SRC_A;
            cpu_arch_pkg::OP_INX, cpu_arch_pkg::OP_DEX,
            cpu_arch_pkg::OP_STX_ABS: dec_src = cpu_ctrl_pkg::SRC_X;
            cpu_arch_pkg::OP_INY, cpu_arch_pkg::OP_DEY,
            cpu_arch_pkg::OP_STY_ABS: dec_src = cpu_ctrl_pkg::SRC_Y;
            default: dec_src = cpu_ctrl_pkg::SRC_MEM;
        endcase

        case (opcode)
            cpu_arch_pkg::OP_LDA_IMM, cpu_arch_pkg::OP_ADC_IMM, cpu_arch_pkg::OP_SBC_IMM,
            cpu_arch_pkg::OP_AND_IMM, cpu_arch_pkg::OP_ORA_IMM,
            cpu_arch_pkg::OP_EOR_IMM: dec_dst = cpu_ctrl_pkg::DST_A;
            cpu_arch_pkg::OP_LDX_IMM, cpu_arch_pkg::OP_TAX, cpu_arch_pkg::OP_INX,
            cpu_arch_pkg::OP_DEX: dec_dst = cpu_ctrl_pkg::DST_X;
            cpu_arch_pkg::OP_LDY_IMM, cpu_arch_pkg::OP_TAY, cpu_arch_pkg::OP_INY,
            cpu_arch_pkg::OP_DEY: dec_dst = cpu_ctrl_pkg::DST_Y;
            cpu_arch_pkg::OP_CLC, cpu_arch_pkg::OP_SEC: dec_dst = cpu_ctrl_pkg::DST_C;
            default: dec_dst = cpu_ctrl_pkg::DST_NONE;
        endcase

        case (opcode)
            cpu_arch_pkg::OP_BCC, cpu_arch_pkg::OP_BCS: ctrl.branch_cond = cpu_ctrl_pkg::BR_C;
            cpu_arch_pkg::OP_BEQ, cpu_arch_pkg::OP_BNE: ctrl.branch_cond = cpu_ctrl_pkg::BR_Z;
            cpu_arch_pkg::OP_BMI, cpu_arch_pkg::OP_BPL: ctrl.branch_cond = cpu_ctrl_pkg::BR_N;
            default: ctrl.branch_cond = cpu_ctrl_pkg::BR_NONE;
        endcase
    end

    // branch on flag clear
    assign ctrl.branch_inv = opcode inside {cpu_arch_pkg::OP_BCC, cpu_arch_pkg::OP_BNE,
                                            cpu_arch_pkg::OP_BPL};
    assign ctrl.operand_inv = (opcode == cpu_arch_pkg::OP_SBC_IMM);
    assign ctrl.carry_sel = (opcode == cpu_arch_pkg::OP_CLC) ? cpu_ctrl_pkg::CARRY_ZERO :
                            (opcode == cpu_arch_pkg::OP_SEC) ? cpu_ctrl_pkg::CARRY_ONE :
                            cpu_ctrl_pkg::CARRY_USE_C;
    assign ctrl.alu_src = dec_src;
    assign ctrl.store_src = dec_src;

    assign is_store = opcode inside {cpu_arch_pkg::OP_STA_ABS, cpu_arch_pkg::OP_STX_ABS,
                                     cpu_arch_pkg::OP_STY_ABS};
    assign is_abs = is_store || (opcode == cpu_arch_pkg::OP_JMP_ABS);
    // second byte is consumed by immediates, branches and absolutes
    assign needs_operand = is_abs || (ctrl.branch_cond != cpu_ctrl_pkg::BR_NONE) ||
                           (opcode inside {cpu_arch_pkg::OP_LDA_IMM, cpu_arch_pkg::OP_LDX_IMM,
                                           cpu_arch_pkg::OP_LDY_IMM, cpu_arch_pkg::OP_ADC_IMM,
                                           cpu_arch_pkg::OP_SBC_IMM, cpu_arch_pkg::OP_AND_IMM,
                                           cpu_arch_pkg::OP_ORA_IMM, cpu_arch_pkg::OP_EOR_IMM});

    // compute in OPERAND, write back during the next FETCH
    assign ctrl.alu_op = (state == cpu_ctrl_pkg::ST_OPERAND) ? dec_op : cpu_ctrl_pkg::ALU_HOLD;
    assign ctrl.alu_dst = (state == cpu_ctrl_pkg::ST_FETCH) ? dec_dst : cpu_ctrl_pkg::DST_NONE;
    assign ctrl.upd_nz = (state == cpu_ctrl_pkg::ST_FETCH) &&
                         (dec_dst inside {cpu_ctrl_pkg::DST_A, cpu_ctrl_pkg::DST_X,
                                          cpu_ctrl_pkg::DST_Y});
    assign ctrl.upd_c = (state == cpu_ctrl_pkg::ST_FETCH) &&
                        (opcode inside {cpu_arch_pkg::OP_ADC_IMM, cpu_arch_pkg::OP_SBC_IMM});

    ////////////////////////////////////////////////////////////
    // sequencing and PC

    assign pc_inc = pc + 1'b1;
    assign rel_off = {{(cpu_arch_pkg::ADDR_W - cpu_arch_pkg::DATA_W)
                       {i_r_data[cpu_arch_pkg::DATA_W-1]}}, i_r_data};

    always_comb begin
        state_nxt = cpu_ctrl_pkg::ST_FETCH;
        pc_nxt = pc;
        case (state)
            cpu_ctrl_pkg::ST_FETCH: begin
                state_nxt = cpu_ctrl_pkg::ST_OPERAND;
                pc_nxt = pc_inc;
            end
            cpu_ctrl_pkg::ST_OPERAND: begin
                state_nxt = is_abs ? cpu_ctrl_pkg::ST_ADDR_HI : cpu_ctrl_pkg::ST_FETCH;
                // offset is relative to the byte after it
                if (ctrl.branch_taken) begin
                    pc_nxt = pc_inc + rel_off;
                end else if (needs_operand) begin
                    pc_nxt = pc_inc;
                end
            end
            cpu_ctrl_pkg::ST_ADDR_HI: begin
                state_nxt = is_store ? cpu_ctrl_pkg::ST_STORE : cpu_ctrl_pkg::ST_FETCH;
                pc_nxt = is_store ? pc_inc : {i_r_data, addr_lo};
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state <= cpu_ctrl_pkg::ST_FETCH;
            pc <= cpu_arch_pkg::RESET_PC;
            opcode <= cpu_arch_pkg::OP_NOP;
        end else if (i_clock_en) begin
            state <= state_nxt;
            pc <= pc_nxt;
            if (state == cpu_ctrl_pkg::ST_FETCH) begin
                opcode <= cpu_arch_pkg::opcode_e'(i_r_data);
            end
        end
    end

    // absolute address bytes
    always_ff @(posedge i_clock) begin
        if (i_clock_en && state == cpu_ctrl_pkg::ST_OPERAND) begin
            addr_lo <= i_r_data;
        end
        if (i_clock_en && state == cpu_ctrl_pkg::ST_ADDR_HI) begin
            addr_hi <= i_r_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory bus

    assign o_addr = (state == cpu_ctrl_pkg::ST_STORE) ? {addr_hi, addr_lo} : pc;
    assign o_mem_r_en = (state != cpu_ctrl_pkg::ST_STORE);
    assign o_mem_w_en = (state == cpu_ctrl_pkg::ST_STORE) && i_clock_en;

    // writes only in STORE, and only for a store opcode
    a_write_in_store: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_mem_w_en |-> (state == cpu_ctrl_pkg::ST_STORE) && is_store)
        else $error("write outside the STORE state of a store opcode");

endmodule

`default_nettype wire

/* hw/cpu_alu.sv */
`default_nettype none

module cpu_alu (
    input  wire logic                            i_clock,
    input  wire logic                            i_rst_n,
    input  wire logic                            i_clock_en,
    input  wire logic [cpu_arch_pkg::DATA_W-1:0] i_r_data,
    cpu_ctrl_if.execute                          ctrl,
    cpu_alu_if.execute                           alu
);

    localparam int W = cpu_arch_pkg::DATA_W;

    logic [W-1:0] op_a;
    logic [W-1:0] op_b;
    logic [W-1:0] result;
    logic [W:0]   sum;
    logic         carry_in;
    logic         carry_out;

    always_comb begin
        case (ctrl.alu_src)
            cpu_ctrl_pkg::SRC_A: op_a = alu.reg_a;
            cpu_ctrl_pkg::SRC_X: op_a = alu.reg_x;
            cpu_ctrl_pkg::SRC_Y: op_a = alu.reg_y;
            default:             op_a = i_r_data;
        endcase
    end

    // immediate operand, inverted for subtract
    assign op_b = ctrl.operand_inv ? ~i_r_data : i_r_data;

    always_comb begin
        case (ctrl.carry_sel)
            cpu_ctrl_pkg::CARRY_ZERO: carry_in = 1'b0;
            cpu_ctrl_pkg::CARRY_ONE:  carry_in = 1'b1;
            default:                  carry_in = alu.reg_c;
        endcase
    end

    assign sum = {1'b0, op_a} + {1'b0, op_b} + {{W{1'b0}}, carry_in};

    always_comb begin
        // carry passes through unless adding, CLC/SEC rely on this
        carry_out = carry_in;
        case (ctrl.alu_op)
            cpu_ctrl_pkg::ALU_ADD: begin
                result = sum[W-1:0];
                carry_out = sum[W];
            end
            cpu_ctrl_pkg::ALU_AND: result = op_a & op_b;
            cpu_ctrl_pkg::ALU_OR:  result = op_a | op_b;
            cpu_ctrl_pkg::ALU_EOR: result = op_a ^ op_b;
            cpu_ctrl_pkg::ALU_INC: result = op_a + 1'b1;
            cpu_ctrl_pkg::ALU_DEC: result = op_a - 1'b1;
            default:               result = op_a;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            alu.alu_out <= '0;
            alu.n_out <= 1'b0;
            alu.z_out <= 1'b0;
            alu.c_out <= 1'b0;
        end else if (i_clock_en && ctrl.alu_op != cpu_ctrl_pkg::ALU_HOLD) begin
            alu.alu_out <= result;
            alu.n_out <= result[W-1];
            alu.z_out <= (result == '0);
            alu.c_out <= carry_out;
        end
    end

    // inverted operand only ever feeds the adder
    a_alu_op_known: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        ctrl.alu_op inside {cpu_ctrl_pkg::ALU_HOLD, cpu_ctrl_pkg::ALU_PASS, cpu_ctrl_pkg::ALU_ADD,
                            cpu_ctrl_pkg::ALU_AND, cpu_ctrl_pkg::ALU_OR, cpu_ctrl_pkg::ALU_EOR,
                            cpu_ctrl_pkg::ALU_INC, cpu_ctrl_pkg::ALU_DEC} &&
        (!ctrl.operand_inv ||
         ctrl.alu_op inside {cpu_ctrl_pkg::ALU_HOLD, cpu_ctrl_pkg::ALU_ADD}))
        else $error("alu_op outside alu_op_e or inverted operand outside an add");

endmodule

`default_nettype wire

/* hw/cpu_regfile.sv */
`default_nettype none

module cpu_regfile (
    input  wire logic                       i_clock,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_clock_en,
    output logic [cpu_arch_pkg::DATA_W-1:0] o_w_data,
    cpu_ctrl_if.result                      ctrl,
    cpu_alu_if.result                       alu
);

    logic [cpu_arch_pkg::DATA_W-1:0] reg_a;
    logic [cpu_arch_pkg::DATA_W-1:0] reg_x;
    logic [cpu_arch_pkg::DATA_W-1:0] reg_y;
    logic                            flag_n;
    logic                            flag_z;
    logic                            flag_c;

    logic a_en;
    logic x_en;
    logic y_en;
    logic nz_en;
    logic c_en;

    assign a_en = i_clock_en && (ctrl.alu_dst == cpu_ctrl_pkg::DST_A);
    assign x_en = i_clock_en && (ctrl.alu_dst == cpu_ctrl_pkg::DST_X);
    assign y_en = i_clock_en && (ctrl.alu_dst == cpu_ctrl_pkg::DST_Y);
    assign nz_en = i_clock_en && ctrl.upd_nz;
    // CLC/SEC land here through DST_C
    assign c_en = i_clock_en && (ctrl.upd_c || ctrl.alu_dst == cpu_ctrl_pkg::DST_C);

    ////////////////////////////////////////////////////////////
    // architectural registers

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            reg_a <= cpu_arch_pkg::RESET_A;
            reg_x <= cpu_arch_pkg::RESET_X;
            reg_y <= cpu_arch_pkg::RESET_Y;
            flag_n <= cpu_arch_pkg::RESET_N;
            flag_z <= cpu_arch_pkg::RESET_Z;
            flag_c <= cpu_arch_pkg::RESET_C;
        end else begin
            if (a_en) begin
                reg_a <= alu.alu_out;
            end
            if (x_en) begin
                reg_x <= alu.alu_out;
            end
            if (y_en) begin
                reg_y <= alu.alu_out;
            end
            if (nz_en) begin
                flag_n <= alu.n_out;
                flag_z <= alu.z_out;
            end
            if (c_en) begin
                flag_c <= alu.c_out;
            end
        end
    end

    // operands for the ALU
    assign alu.reg_a = reg_a;
    assign alu.reg_x = reg_x;
    assign alu.reg_y = reg_y;
    assign alu.reg_c = flag_c;

    ////////////////////////////////////////////////////////////
    // branch condition and store data

    always_comb begin
        case (ctrl.branch_cond)
            cpu_ctrl_pkg::BR_C: ctrl.branch_taken = flag_c ^ ctrl.branch_inv;
            cpu_ctrl_pkg::BR_Z: ctrl.branch_taken = flag_z ^ ctrl.branch_inv;
            cpu_ctrl_pkg::BR_N: ctrl.branch_taken = flag_n ^ ctrl.branch_inv;
            default:            ctrl.branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.store_src)
            cpu_ctrl_pkg::SRC_X: o_w_data = reg_x;
            cpu_ctrl_pkg::SRC_Y: o_w_data = reg_y;
            default:             o_w_data = reg_a;
        endcase
    end

    // writeback only in FETCH, so never in two cycles running
    a_one_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (a_en || x_en || y_en) |-> $onehot0({a_en, x_en, y_en}) ##1 !(a_en || x_en || y_en))
        else $error("more than one register write");

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`default_nettype none

module cpu_core (
    input  wire logic                            i_clock,
    input  wire logic                            i_rst_n,
    input  wire logic                            i_clock_en,
    input  wire logic [cpu_arch_pkg::DATA_W-1:0] i_r_data,
    output logic [cpu_arch_pkg::ADDR_W-1:0]      o_addr,
    output logic                                 o_mem_r_en,
    output logic                                 o_mem_w_en,
    output logic [cpu_arch_pkg::DATA_W-1:0]      o_w_data
);

    cpu_ctrl_if ctrl_if ();
    cpu_alu_if  alu_if ();

    // sequencer, PC and bus address
    cpu_decode decode_i (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_clock_en (i_clock_en),
        .i_r_data   (i_r_data),
        .o_addr     (o_addr),
        .o_mem_r_en (o_mem_r_en),
        .o_mem_w_en (o_mem_w_en),
        .ctrl       (ctrl_if.decode)
    );

    cpu_alu alu_i (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_clock_en (i_clock_en),
        .i_r_data   (i_r_data),
        .ctrl       (ctrl_if.execute),
        .alu        (alu_if.execute)
    );

    // registers, flags and store data
    cpu_regfile regfile_i (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_clock_en (i_clock_en),
        .o_w_data   (o_w_data),
        .ctrl       (ctrl_if.result),
        .alu        (alu_if.result)
    );

endmodule

`default_nettype wire

/* include/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS  = 5;
localparam int MAX_PROG   = 48;
localparam int MAX_STORES = 8;
localparam int PROG_W     = 8 * MAX_PROG;
localparam int STORE_W    = 24 * MAX_STORES;

string              test_name [NUM_TESTS];
int                 prog_len  [NUM_TESTS];
logic [PROG_W-1:0]  prog_img  [NUM_TESTS];
int                 store_cnt [NUM_TESTS];
logic [STORE_W-1:0] store_img [NUM_TESTS];

// program bytes run left to right from RESET_PC, one literal per instruction
// stores are {address, data} in the order they must appear
task automatic fill_test_table();
    test_name[0] = "immediate loads and stores";
    prog_len[0]  = 18;
    prog_img[0]  = PROG_W'({16'hA937, 16'hA2C5, 16'hA000, 24'h8D0010, 24'h8E0110,
                            24'h8C0210, 24'h4C0F02});
    store_cnt[0] = 3;
    store_img[0] = STORE_W'({24'h1000_37, 24'h1001_C5, 24'h1002_00});

    test_name[1] = "adc sbc and logic ops";
    prog_len[1]  = 39;
    prog_img[1]  = PROG_W'({8'h18, 16'hA9F0, 16'h6920, 24'h8D1010, 16'h6905, 24'h8D1110,
                            8'h38, 16'hE920, 24'h8D1210, 16'hE901, 24'h8D1310,
                            16'h293C, 16'h0981, 24'h8D1410, 16'h49FF, 24'h8D1510,
                            24'h4C2402});
    store_cnt[1] = 6;
    store_img[1] = STORE_W'({24'h1010_10, 24'h1011_16, 24'h1012_F6, 24'h1013_F4,
                             24'h1014_B5, 24'h1015_4A});

    test_name[2] = "transfers, inc and dec";
    prog_len[2]  = 28;
    prog_img[2]  = PROG_W'({16'hA9FE, 8'hAA, 8'hE8, 8'hE8, 24'h8E2010, 8'hCA, 24'h8E2110,
                            16'hA901, 8'hA8, 8'h88, 8'h88, 24'h8C2210, 8'hC8, 8'hC8,
                            24'h8C2310, 24'h4C1902});
    store_cnt[2] = 4;
    store_img[2] = STORE_W'({24'h1020_00, 24'h1021_FF, 24'h1022_FF, 24'h1023_01});

    // every taken branch skips a store to 10EE
    test_name[3] = "branches on z and n";
    prog_len[3]  = 47;
    prog_img[3]  = PROG_W'({16'hA900, 16'hD003, 24'h8D3010, 16'hF003, 24'h8DEE10,
                            16'h3003, 24'h8D3110, 16'h1003, 24'h8DEE10,
                            16'hA980, 16'hF003, 24'h8D3210, 16'hD003, 24'h8DEE10,
                            16'h1003, 24'h8D3310, 16'h3003, 24'h8DEE10, 24'h4C2C02});
    store_cnt[3] = 4;
    store_img[3] = STORE_W'({24'h1030_00, 24'h1031_00, 24'h1032_80, 24'h1033_80});

    // ends in a backward BNE loop counting X from FD up to 00
    test_name[4] = "branches on c and jmp";
    prog_len[4]  = 41;
    prog_img[4]  = PROG_W'({16'hA95A, 8'h38, 16'h9003, 24'h8D4010, 16'hB003, 24'h8DEE10,
                            8'h18, 16'hB003, 24'h8D4110, 16'h9003, 24'h8DEE10,
                            24'h4C1E02, 24'h8DEE10, 16'hA2FD, 8'hE8, 16'hD0FD,
                            24'h8E4210, 24'h4C2602});
    store_cnt[4] = 3;
    store_img[4] = STORE_W'({24'h1040_5A, 24'h1041_5A, 24'h1042_00});
endtask

`endif

/* tests/cpu_core_tb.sv */
`default_nettype none

module cpu_core_tb;

    `include "tb_programs.svh"

    localparam int NUM_PASSES = 2;

    logic        clock;
    logic        rst_n;
    logic        clock_en;
    logic [7:0]  r_data;
    logic [15:0] addr;
    logic        mem_r_en;
    logic        mem_w_en;
    logic [7:0]  w_data;

    logic [7:0]  mem [0:65535];
    logic [23:0] nostall_log [NUM_TESTS][MAX_STORES];

    int check_errors = 0;
    int runs_ok = 0;
    int runs_bad = 0;
    int watchdog_cycles = 0;
    bit table_ready = 1'b0;

    cpu_core dut_i (
        .i_clock    (clock),
        .i_rst_n    (rst_n),
        .i_clock_en (clock_en),
        .i_r_data   (r_data),
        .o_addr     (addr),
        .o_mem_r_en (mem_r_en),
        .o_mem_w_en (mem_w_en),
        .o_w_data   (w_data)
    );

    // read data answers the address in the same cycle
    assign r_data = mem[addr];

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic record_failure(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        check_errors++;
    endtask

    task automatic fill_memory();
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a = 16'(i);
            mem[a] = a[15:8] ^ a[7:0] ^ 8'hC3;
        end
    endtask

    task automatic load_program(input int t);
        logic [PROG_W-1:0] img;
        logic [15:0]       a;
        img = prog_img[t];
        fill_memory();
        for (int i = 0; i < prog_len[t]; i++) begin
            a = cpu_arch_pkg::RESET_PC + 16'(i);
            mem[a] = img[8*(prog_len[t]-1-i) +: 8];
        end
    endtask

    function automatic logic [23:0] expected_store(input int t, input int idx);
        logic [STORE_W-1:0] img;
        img = store_img[t];
        return img[24*(store_cnt[t]-1-idx) +: 24];
    endfunction

    ////////////////////////////////////////////////////////////
    // one test run, with or without enable gaps

    task automatic run_test(input int t, input bit stalled);
        int          seen;
        int          errors_at_start;
        bit          first;
        logic [23:0] exp_pair;
        errors_at_start = check_errors;
        seen = 0;
        first = 1'b1;
        @(negedge clock);
        rst_n = 1'b0;
        clock_en = 1'b1;
        load_program(t);
        repeat (4) @(negedge clock);
        rst_n = 1'b1;
        while (seen < store_cnt[t]) begin
            clock_en = stalled ? (($urandom % 4) != 0) : 1'b1;
            #5;
            if (first) begin
                assert (addr == cpu_arch_pkg::RESET_PC && mem_r_en && !mem_w_en)
                else record_failure($sformatf("%s: after reset addr %h r_en %b w_en %b",
                                              test_name[t], addr, mem_r_en, mem_w_en));
                first = 1'b0;
            end
            if (!clock_en) begin
                assert (!mem_w_en)
                else record_failure($sformatf("%s: write while stalled", test_name[t]));
            end
            if (mem_w_en) begin
                exp_pair = expected_store(t, seen);
                assert ({addr, w_data} == exp_pair)
                else record_failure($sformatf("%s: store %0d wrote %h to %h, expected %h to %h",
                                              test_name[t], seen, w_data, addr,
                                              exp_pair[7:0], exp_pair[23:8]));
                if (!stalled) begin
                    nostall_log[t][seen] = {addr, w_data};
                end else begin
                    assert ({addr, w_data} == nostall_log[t][seen])
                    else record_failure($sformatf("%s: store %0d differs from unstalled run",
                                                  test_name[t], seen));
                end
                mem[addr] = w_data;
                seen++;
            end
            @(negedge clock);
        end
        clock_en = 1'b1;
        if (check_errors == errors_at_start) begin
            runs_ok++;
            $display("ok   %s, %s, %0d stores", test_name[t],
                     stalled ? "with stalls" : "no stalls", seen);
        end else begin
            runs_bad++;
            $display("FAIL %s, %s, %0d errors", test_name[t],
                     stalled ? "with stalls" : "no stalls", check_errors - errors_at_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        int total_stores;
        rst_n = 1'b0;
        clock_en = 1'b1;
        total_stores = 0;
        void'($urandom(71));
        fill_memory();
        fill_test_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_stores += store_cnt[t];
        end
        watchdog_cycles = total_stores * NUM_PASSES * 40;
        table_ready = 1'b1;
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_test(t, pass == 1);
            end
        end
        $display("runs ok: %0d, runs failing: %0d, failed checks: %0d",
                 runs_ok, runs_bad, check_errors);
        if (check_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clock);
        $display("the run timed out after %0d cycles without seeing all stores",
                 watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hw/cpu_arch_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/cpu_ctrl_if.sv
hw/cpu_alu_if.sv
hw/cpu_decode.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/cpu_core.sv
tests/cpu_core_tb.sv
